//--- logic/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram
    import rv32i_pkg::*;
#(
    parameter int ram_words = 256
) (
    input  logic                         clk,
    input  logic [$clog2(ram_words)-1:0] ram_addr,
    input  byte_mask_t                   ram_wmask,
    input  word_t                        ram_wdata,
    output word_t                        ram_rdata
);

    word_t mem [ram_words];

    // Per-byte write
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (ram_wmask[i]) begin
                mem[ram_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
            end
        end
    end

    // Registered read, old data on a same-word write
    always_ff @(posedge clk) begin
        ram_rdata <= mem[ram_addr];
    end

endmodule

`default_nettype wire

//--- logic/load_align.sv
`timescale 1ns/1ns
`default_nettype none

module load_align
    import rv32i_pkg::*;
(
    input  word_t      ram_rdata,
    input  logic [1:0] wb_offset,
    output word_t      ld_w,
    output word_t      ld_b,
    output word_t      ld_bu,
    output word_t      ld_h,
    output word_t      ld_hu
);

    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    assign lane_b  = ram_rdata[{wb_offset, 3'b000} +: 8];
    assign lane_h  = wb_offset[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    assign ld_w  = ram_rdata;
    assign ld_b  = {{24{lane_b[7]}}, lane_b};          // Sign extend
    assign ld_bu = {24'b0, lane_b};
    assign ld_h  = {{16{lane_h[15]}}, lane_h};
    assign ld_hu = {16'b0, lane_h};

endmodule

`default_nettype wire

//--- logic/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage
    import rv32i_pkg::*;
#(
    parameter int ram_words = 256
) (
    input  logic                         ex_valid,
    input  logic                         ex_mem_read,
    input  logic                         ex_mem_write,
    input  funct3_t                      ex_funct3,
    input  word_t                        ex_alu_out,
    input  word_t                        ex_store_v,
    output logic [$clog2(ram_words)-1:0] ram_addr,
    output byte_mask_t                   ram_wmask,
    output word_t                        ram_wdata
);

    localparam int addr_w = $clog2(ram_words);

    logic [1:0]  offset;
    logic [4:0]  lane_sh;
    logic        mem_acc;
    byte_mask_t  wmask_raw;

    assign offset   = ex_alu_out[1:0];
    assign lane_sh  = {offset, 3'b000};                // Byte offset in bits
    assign ram_addr = ex_alu_out[addr_w+1:2];          // Word index
    assign mem_acc  = ex_valid && (ex_mem_read || ex_mem_write);

    always_comb begin
        wmask_raw = 4'b1111;
        ram_wdata = ex_store_v;
        case (ex_funct3)
            f3_b, f3_bu: begin
                wmask_raw = 4'b0001 << offset;
                ram_wdata = {24'b0, ex_store_v[7:0]} << lane_sh;
            end
            f3_h, f3_hu: begin
                wmask_raw = 4'b0011 << offset;
                ram_wdata = {16'b0, ex_store_v[15:0]} << lane_sh;
            end
            default: ;                                 // Full word
        endcase
    end

    assign ram_wmask = (ex_valid && ex_mem_write) ? wmask_raw : 4'b0000;

    // Alignment and range of every data access
    always_comb begin
        if (mem_acc) begin
            a_align_h: assert final (!((ex_funct3 == f3_h || ex_funct3 == f3_hu) && offset[0]))
                else $error("misaligned half access at %h", ex_alu_out);
            a_align_w: assert final (!(ex_funct3 == f3_w && offset != 2'b00))
                else $error("misaligned word access at %h", ex_alu_out);
            a_range: assert final (ex_alu_out[31:2] < 30'(ram_words))
                else $error("data address %h beyond RAM", ex_alu_out);
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_wb_reg.sv
`timescale 1ns/1ns
`default_nettype none

module mem_wb_reg
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     ex_valid,
    input  word_t    ex_pc,
    input  funct3_t  ex_funct3,
    input  logic     ex_mem_read,
    input  logic     ex_mem_write,
    input  logic     ex_regf_we,
    input  wb_sel_t  ex_wb_sel,
    input  reg_idx_t ex_rd_s,
    input  word_t    ex_alu_out,
    input  word_t    ex_br_en,
    input  word_t    ex_u_imm,
    output logic     wb_valid,
    output word_t    wb_pc,
    output wb_sel_t  wb_sel,
    output logic     wb_regf_we_raw,
    output reg_idx_t wb_rd_s,
    output word_t    wb_alu_out,
    output word_t    wb_br_en,
    output word_t    wb_u_imm,
    output logic [1:0] wb_offset,
    output order_t   wb_order
);

    order_t order_cnt;                                 // Valid entries retired so far

    // ------------------------------------------------------------
    // Control and order counter
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid       <= 1'b0;
            wb_regf_we_raw <= 1'b0;
            wb_order       <= '0;
            order_cnt      <= '0;
        end else begin
            wb_valid       <= ex_valid;
            wb_regf_we_raw <= ex_regf_we;              // Gated with valid in wb_stage
            wb_order       <= order_cnt;
            if (ex_valid) begin
                order_cnt <= order_cnt + 64'd1;
            end
        end
    end

    // ------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        wb_pc      <= ex_pc;
        wb_sel     <= ex_wb_sel;
        wb_rd_s    <= ex_rd_s;
        wb_alu_out <= ex_alu_out;
        wb_br_en   <= ex_br_en;
        wb_u_imm   <= ex_u_imm;
        wb_offset  <= ex_alu_out[1:0];                 // Byte offset for load_align
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        ex_valid |-> !(ex_mem_read && ex_mem_write))
        else $error("load and store in one entry");

    // Decode must pair the load width with the matching writeback select
    a_load_sel: assert property (@(posedge clk) disable iff (rst)
        (ex_valid && ex_mem_read) |->
            (ex_funct3 == f3_w  && ex_wb_sel == lw_wb)  ||
            (ex_funct3 == f3_b  && ex_wb_sel == lb_wb)  ||
            (ex_funct3 == f3_bu && ex_wb_sel == lbu_wb) ||
            (ex_funct3 == f3_h  && ex_wb_sel == lh_wb)  ||
            (ex_funct3 == f3_hu && ex_wb_sel == lhu_wb))
        else $error("load funct3 %0d does not match wb_sel %s", ex_funct3, ex_wb_sel.name());

endmodule

`default_nettype wire

//--- logic/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     wb_regf_we,
    input  reg_idx_t wb_rd_s,
    input  word_t    wb_rd_v,
    input  reg_idx_t rs1_s,
    input  reg_idx_t rs2_s,
    output word_t    rs1_v,
    output word_t    rs2_v
);

    word_t regs [32];
    logic  wr_en;

    assign wr_en = wb_regf_we && (wb_rd_s != 5'd0);    // x0 stays zero

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_rd_s] <= wb_rd_v;
        end
    end

    // Read ports with write-through bypass
    always_comb begin
        if (rs1_s == 5'd0) begin
            rs1_v = '0;
        end else if (wr_en && (wb_rd_s == rs1_s)) begin
            rs1_v = wb_rd_v;
        end else begin
            rs1_v = regs[rs1_s];
        end
    end

    always_comb begin
        if (rs2_s == 5'd0) begin
            rs2_v = '0;
        end else if (wr_en && (wb_rd_s == rs2_s)) begin
            rs2_v = wb_rd_v;
        end else begin
            rs2_v = regs[rs2_s];
        end
    end

endmodule

`default_nettype wire

//--- logic/rv32i_backend.sv
`timescale 1ns/1ns
`default_nettype none

module rv32i_backend
    import rv32i_pkg::*;
#(
    parameter int ram_words = 256
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     ex_valid,
    input  word_t    ex_pc,
    input  funct3_t  ex_funct3,
    input  logic     ex_mem_read,
    input  logic     ex_mem_write,
    input  logic     ex_regf_we,
    input  wb_sel_t  ex_wb_sel,
    input  reg_idx_t ex_rd_s,
    input  word_t    ex_alu_out,
    input  word_t    ex_br_en,
    input  word_t    ex_u_imm,
    input  word_t    ex_store_v,
    input  reg_idx_t rs1_s,
    input  reg_idx_t rs2_s,
    output word_t    rs1_v,
    output word_t    rs2_v,
    output logic     wb_valid,
    output word_t    wb_pc,
    output reg_idx_t wb_rd_s,
    output word_t    wb_rd_v,
    output logic     wb_regf_we,
    output order_t   wb_order
);

    // ------------------------------------------------------------
    // Memory stage
    // ------------------------------------------------------------
    logic [$clog2(ram_words)-1:0] ram_addr;
    byte_mask_t                   ram_wmask;
    word_t                        ram_wdata;
    word_t                        ram_rdata;

    mem_stage #(.ram_words(ram_words)) u_mem_stage (
        .ex_valid     (ex_valid),
        .ex_mem_read  (ex_mem_read),
        .ex_mem_write (ex_mem_write),
        .ex_funct3    (ex_funct3),
        .ex_alu_out   (ex_alu_out),
        .ex_store_v   (ex_store_v),
        .ram_addr     (ram_addr),
        .ram_wmask    (ram_wmask),
        .ram_wdata    (ram_wdata)
    );

    data_ram #(.ram_words(ram_words)) u_data_ram (
        .clk       (clk),
        .ram_addr  (ram_addr),
        .ram_wmask (ram_wmask),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    // ------------------------------------------------------------
    // MEM/WB register
    // ------------------------------------------------------------
    wb_sel_t    wb_sel;
    logic       wb_regf_we_raw;
    word_t      wb_alu_out;
    word_t      wb_br_en;
    word_t      wb_u_imm;
    logic [1:0] wb_offset;

    mem_wb_reg u_mem_wb_reg (
        .clk            (clk),
        .rst            (rst),
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_funct3      (ex_funct3),
        .ex_mem_read    (ex_mem_read),
        .ex_mem_write   (ex_mem_write),
        .ex_regf_we     (ex_regf_we),
        .ex_wb_sel      (ex_wb_sel),
        .ex_rd_s        (ex_rd_s),
        .ex_alu_out     (ex_alu_out),
        .ex_br_en       (ex_br_en),
        .ex_u_imm       (ex_u_imm),
        .wb_valid       (wb_valid),
        .wb_pc          (wb_pc),
        .wb_sel         (wb_sel),
        .wb_regf_we_raw (wb_regf_we_raw),
        .wb_rd_s        (wb_rd_s),
        .wb_alu_out     (wb_alu_out),
        .wb_br_en       (wb_br_en),
        .wb_u_imm       (wb_u_imm),
        .wb_offset      (wb_offset),
        .wb_order       (wb_order)
    );

    // ------------------------------------------------------------
    // Writeback
    // ------------------------------------------------------------
    word_t ld_w;
    word_t ld_b;
    word_t ld_bu;
    word_t ld_h;
    word_t ld_hu;

    load_align u_load_align (
        .ram_rdata (ram_rdata),
        .wb_offset (wb_offset),
        .ld_w      (ld_w),
        .ld_b      (ld_b),
        .ld_bu     (ld_bu),
        .ld_h      (ld_h),
        .ld_hu     (ld_hu)
    );

    wb_stage u_wb_stage (
        .wb_valid       (wb_valid),
        .wb_regf_we_raw (wb_regf_we_raw),
        .wb_sel         (wb_sel),
        .wb_pc          (wb_pc),
        .wb_alu_out     (wb_alu_out),
        .wb_br_en       (wb_br_en),
        .wb_u_imm       (wb_u_imm),
        .ld_w           (ld_w),
        .ld_b           (ld_b),
        .ld_bu          (ld_bu),
        .ld_h           (ld_h),
        .ld_hu          (ld_hu),
        .wb_rd_v        (wb_rd_v),
        .wb_regf_we     (wb_regf_we)
    );

    regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .wb_regf_we (wb_regf_we),
        .wb_rd_s    (wb_rd_s),
        .wb_rd_v    (wb_rd_v),
        .rs1_s      (rs1_s),
        .rs2_s      (rs2_s),
        .rs1_v      (rs1_v),
        .rs2_v      (rs2_v)
    );

endmodule

`default_nettype wire

//--- logic/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------
    typedef logic [31:0] word_t;       // Data, address or PC
    typedef logic [4:0]  reg_idx_t;
    typedef logic [63:0] order_t;      // Retire sequence number
    typedef logic [3:0]  byte_mask_t;
    typedef logic [2:0]  funct3_t;

    // ------------------------------------------------------------
    // Load/store width codes (funct3)
    // ------------------------------------------------------------
    localparam funct3_t f3_b  = 3'd0;
    localparam funct3_t f3_h  = 3'd1;
    localparam funct3_t f3_w  = 3'd2;
    localparam funct3_t f3_bu = 3'd4;
    localparam funct3_t f3_hu = 3'd5;

    // ------------------------------------------------------------
    // Writeback value select
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        alu_out_wb,
        br_en_wb,
        u_imm_wb,
        lw_wb,
        pc_plus4_wb,
        lb_wb,
        lbu_wb,
        lh_wb,
        lhu_wb
    } wb_sel_t;

endpackage

`default_nettype wire

//--- logic/wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

module wb_stage
    import rv32i_pkg::*;
(
    input  logic    wb_valid,
    input  logic    wb_regf_we_raw,
    input  wb_sel_t wb_sel,
    input  word_t   wb_pc,
    input  word_t   wb_alu_out,
    input  word_t   wb_br_en,
    input  word_t   wb_u_imm,
    input  word_t   ld_w,
    input  word_t   ld_b,
    input  word_t   ld_bu,
    input  word_t   ld_h,
    input  word_t   ld_hu,
    output word_t   wb_rd_v,
    output logic    wb_regf_we
);

    always_comb begin
        wb_rd_v = '0;
        case (wb_sel)
            alu_out_wb:  wb_rd_v = wb_alu_out;
            br_en_wb:    wb_rd_v = wb_br_en;
            u_imm_wb:    wb_rd_v = wb_u_imm;
            lw_wb:       wb_rd_v = ld_w;
            pc_plus4_wb: wb_rd_v = wb_pc + 32'd4;      // Link value for jal/jalr
            lb_wb:       wb_rd_v = ld_b;
            lbu_wb:      wb_rd_v = ld_bu;
            lh_wb:       wb_rd_v = ld_h;
            lhu_wb:      wb_rd_v = ld_hu;
            default:     wb_rd_v = '0;
        endcase
    end

    assign wb_regf_we = wb_valid && wb_regf_we_raw;

endmodule

`default_nettype wire

//--- rv32i_backend.f
logic/rv32i_pkg.sv
logic/mem_stage.sv
logic/data_ram.sv
logic/mem_wb_reg.sv
logic/load_align.sv
logic/wb_stage.sv
logic/regfile.sv
logic/rv32i_backend.sv
sim/backend_checker.sv
sim/tb_rv32i_backend.sv

//--- sim/backend_checker.sv
`timescale 1ns/1ns
`default_nettype none

module backend_checker
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     sweep,
    input  int       drv_line,
    input  int       reg_line,
    input  reg_idx_t rs1_s,
    input  reg_idx_t rs2_s,
    input  word_t    rs1_v,
    input  word_t    rs2_v,
    input  logic     wb_valid,
    input  word_t    wb_pc,
    input  reg_idx_t wb_rd_s,
    input  word_t    wb_rd_v,
    input  logic     wb_regf_we,
    input  order_t   wb_order,
    output int       tests,
    output int       checks,
    output int       errors
);

    localparam int max_lines = 64;

    logic     i_valid  [max_lines];
    word_t    i_pc     [max_lines];
    reg_idx_t i_rd     [max_lines];
    word_t    i_exp_v  [max_lines];
    logic     i_exp_we [max_lines];
    reg_idx_t r_idx    [max_lines];
    word_t    r_val    [max_lines];
    int       n_i;
    int       n_r;
    word_t    model [32];                              // Register contents so far
    int       prev_line;                               // Entry now in writeback
    int       retired;                                 // Valid entries past writeback
    int       err_start;

    task automatic read_expected();
        int fd;
        int code;
        logic [7:0] tag;
        logic [8*160-1:0] rest;
        int v, f3, mrd, mwr, we, sel, rd, ewe;
        word_t pc, alu, br, ui, st, ev;
        n_i = 0;
        n_r = 0;
        fd = $fopen("sim/backend_golden.txt", "r");
        if (fd == 0) begin
            $display("Checker could not open sim/backend_golden.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            if (tag == "I") begin
                code = $fscanf(fd, "%d %h %d %d %d %d %d %d %h %h %h %h %h %d",
                               v, pc, f3, mrd, mwr, we, sel, rd, alu, br, ui, st, ev, ewe);
                i_valid[n_i]  = v[0];
                i_pc[n_i]     = pc;
                i_rd[n_i]     = rd[4:0];
                i_exp_v[n_i]  = ev;
                i_exp_we[n_i] = ewe[0];
                n_i++;
            end else if (tag == "R") begin
                code = $fscanf(fd, "%d %h", rd, ev);
                if (code != 2) begin
                    $display("Checker found a malformed R line in the golden file");
                    errors++;
                end
                r_idx[n_r] = rd[4:0];
                r_val[n_r] = ev;
                n_r++;
            end else begin
                code = $fgets(rest, fd);
            end
        end
        $fclose(fd);
    endtask

    task automatic compare_value(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
        end
    endtask

    // Read port value, with bypass from the entry in writeback
    function automatic word_t expected_read(input reg_idx_t s);
        if (s == 5'd0) begin
            return '0;
        end
        if (prev_line >= 0 && i_exp_we[prev_line] && i_rd[prev_line] == s) begin
            return i_exp_v[prev_line];
        end
        return model[s];
    endfunction

    initial begin
        tests     = 0;
        checks    = 0;
        errors    = 0;
        prev_line = -1;
        retired   = 0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        read_expected();
    end

    always @(posedge clk) begin
        prev_line <= drv_line;                         // Entry enters writeback next cycle
    end

    // ------------------------------------------------------------
    // Compare at mid-cycle, when outputs are settled
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst) begin
            err_start = errors;
            if (prev_line >= 0) begin
                compare_value("wb_valid", i_valid[prev_line], wb_valid);
                compare_value("wb_regf_we", i_exp_we[prev_line], wb_regf_we);
                if (i_valid[prev_line]) begin
                    compare_value("wb_pc", i_pc[prev_line], wb_pc);
                    compare_value("wb_rd_s", i_rd[prev_line], wb_rd_s);
                    compare_value("wb_rd_v", i_exp_v[prev_line], wb_rd_v);
                end
            end else begin
                compare_value("wb_valid", 1'b0, wb_valid);
                compare_value("wb_regf_we", 1'b0, wb_regf_we);
            end
            compare_value("wb_order", 64'(retired), wb_order);
            compare_value($sformatf("rs1_v (x%0d)", rs1_s), expected_read(rs1_s), rs1_v);
            compare_value($sformatf("rs2_v (x%0d)", rs2_s), expected_read(rs2_s), rs2_v);
            if (reg_line >= 0) begin
                compare_value($sformatf("final x%0d", r_idx[reg_line]), r_val[reg_line], rs1_v);
                tests++;
                $display("Final x%0d = %h: %s", r_idx[reg_line], r_val[reg_line],
                         (errors == err_start) ? "ok" : "failed");
            end
            if (prev_line >= 0) begin
                tests++;
                $display("Entry %0d %s pc %h: %s", prev_line,
                         i_valid[prev_line] ? "valid " : "bubble", i_pc[prev_line],
                         (errors == err_start) ? "ok" : "failed");
                if (i_exp_we[prev_line] && i_rd[prev_line] != 5'd0) begin
                    model[i_rd[prev_line]] = i_exp_v[prev_line];
                end
                if (i_valid[prev_line]) begin
                    retired++;
                end
            end
            if (sweep) begin
                tests++;
                $display("Reset state, x%0d and x%0d: %s", rs1_s, rs2_s,
                         (errors == err_start) ? "ok" : "failed");
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/backend_golden.txt
# I valid pc funct3 mem_rd mem_wr regf_we wb_sel rd alu_out br_en u_imm store_v exp_rd_v exp_we
# R reg expected_final_value   (wb_sel 0 alu, 1 br, 2 uimm, 3 lw, 4 pc+4, 5 lb, 6 lbu, 7 lh, 8 lhu)
I 1 00000100 0 0 0 1 0 1 12345678 00000000 00000000 00000000 12345678 1
I 1 00000104 0 0 0 1 1 2 00000000 00000001 00000000 00000000 00000001 1
I 1 00000108 0 0 0 1 2 3 00000000 00000000 abcde000 00000000 abcde000 1
I 1 0000010c 0 0 0 1 4 4 00000000 00000000 00000000 00000000 00000110 1
I 0 00000000 0 0 0 0 0 0 00000000 00000000 00000000 00000000 00000000 0
I 1 00000110 2 0 1 0 0 0 00000040 00000000 00000000 8091a2b3 00000040 0
I 1 00000114 2 1 0 1 3 5 00000040 00000000 00000000 00000000 8091a2b3 1
I 1 00000118 0 1 0 1 5 6 00000040 00000000 00000000 00000000 ffffffb3 1
I 1 0000011c 4 1 0 1 6 7 00000041 00000000 00000000 00000000 000000a2 1
I 1 00000120 0 1 0 1 5 8 00000042 00000000 00000000 00000000 ffffff91 1
I 1 00000124 4 1 0 1 6 9 00000043 00000000 00000000 00000000 00000080 1
I 1 00000128 1 1 0 1 7 10 00000040 00000000 00000000 00000000 ffffa2b3 1
I 1 0000012c 5 1 0 1 8 11 00000042 00000000 00000000 00000000 00008091 1
I 1 00000130 0 0 1 0 0 0 00000041 00000000 00000000 11223344 00000041 0
I 1 00000134 1 1 0 1 7 12 00000040 00000000 00000000 00000000 000044b3 1
I 1 00000138 1 0 1 0 0 0 00000042 00000000 00000000 0000f00d 00000042 0
I 1 0000013c 1 1 0 1 7 13 00000042 00000000 00000000 00000000 fffff00d 1
I 1 00000140 0 0 0 1 0 0 deadbeef 00000000 00000000 00000000 deadbeef 1
I 0 00000000 0 0 0 0 0 0 00000000 00000000 00000000 00000000 00000000 0
I 1 00000144 0 0 0 0 0 1 55555555 00000000 00000000 00000000 55555555 0
I 1 00000148 0 0 0 1 0 3 00000777 00000000 00000000 00000000 00000777 1
I 1 0000014c 2 1 0 1 3 14 00000040 00000000 00000000 00000000 f00d44b3 1
R 0 00000000
R 1 12345678
R 3 00000777
R 5 8091a2b3
R 6 ffffffb3
R 10 ffffa2b3
R 12 000044b3
R 13 fffff00d
R 14 f00d44b3
R 31 00000000

//--- sim/tb_rv32i_backend.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv32i_backend
    import rv32i_pkg::*;
();

    localparam int ram_words  = 256;
    localparam int clk_period = 8;
    localparam int max_lines  = 64;

    logic     clk;
    logic     rst;
    logic     ex_valid;
    word_t    ex_pc;
    funct3_t  ex_funct3;
    logic     ex_mem_read;
    logic     ex_mem_write;
    logic     ex_regf_we;
    wb_sel_t  ex_wb_sel;
    reg_idx_t ex_rd_s;
    word_t    ex_alu_out;
    word_t    ex_br_en;
    word_t    ex_u_imm;
    word_t    ex_store_v;
    reg_idx_t rs1_s;
    reg_idx_t rs2_s;
    word_t    rs1_v;
    word_t    rs2_v;
    logic     wb_valid;
    word_t    wb_pc;
    reg_idx_t wb_rd_s;
    word_t    wb_rd_v;
    logic     wb_regf_we;
    order_t   wb_order;

    logic     sweep;                                   // Post-reset register sweep
    int       drv_line;                                // I line driven this cycle, -1 if none
    int       reg_line;                                // R line read this cycle, -1 if none
    int       tests;
    int       checks;
    int       errors;
    logic     loaded;
    logic     load_ok;

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    logic       s_valid [max_lines];
    word_t      s_pc    [max_lines];
    funct3_t    s_f3    [max_lines];
    logic       s_mrd   [max_lines];
    logic       s_mwr   [max_lines];
    logic       s_we    [max_lines];
    logic [3:0] s_sel   [max_lines];
    reg_idx_t   s_rd    [max_lines];
    word_t      s_alu   [max_lines];
    word_t      s_br    [max_lines];
    word_t      s_ui    [max_lines];
    word_t      s_st    [max_lines];
    reg_idx_t   r_idx   [max_lines];
    int         n_i;
    int         n_r;

    rv32i_backend #(.ram_words(ram_words)) u_dut (.*);

    backend_checker u_checker (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic read_stimulus();
        int fd;
        int code;
        logic [7:0] tag;
        logic [8*160-1:0] rest;
        int v, f3, mrd, mwr, we, sel, rd, ewe;
        word_t pc, alu, br, ui, st, ev;
        n_i = 0;
        n_r = 0;
        load_ok = 1'b1;
        fd = $fopen("sim/backend_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/backend_golden.txt");
            load_ok = 1'b0;
            return;
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            if (tag == "I") begin
                code = $fscanf(fd, "%d %h %d %d %d %d %d %d %h %h %h %h %h %d",
                               v, pc, f3, mrd, mwr, we, sel, rd, alu, br, ui, st, ev, ewe);
                if (code != 14) begin
                    $display("Malformed I line %0d in golden file", n_i);
                    load_ok = 1'b0;
                end
                s_valid[n_i] = v[0];
                s_pc[n_i]    = pc;
                s_f3[n_i]    = f3[2:0];
                s_mrd[n_i]   = mrd[0];
                s_mwr[n_i]   = mwr[0];
                s_we[n_i]    = we[0];
                s_sel[n_i]   = sel[3:0];
                s_rd[n_i]    = rd[4:0];
                s_alu[n_i]   = alu;
                s_br[n_i]    = br;
                s_ui[n_i]    = ui;
                s_st[n_i]    = st;
                n_i++;
            end else if (tag == "R") begin
                code = $fscanf(fd, "%d %h", rd, ev);
                r_idx[n_r] = rd[4:0];
                n_r++;
            end else begin
                code = $fgets(rest, fd);               // Comment line
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_entry(input int k);
        ex_valid     <= s_valid[k];
        ex_pc        <= s_pc[k];
        ex_funct3    <= s_f3[k];
        ex_mem_read  <= s_mrd[k];
        ex_mem_write <= s_mwr[k];
        ex_regf_we   <= s_we[k];
        ex_wb_sel    <= wb_sel_t'(s_sel[k]);
        ex_rd_s      <= s_rd[k];
        ex_alu_out   <= s_alu[k];
        ex_br_en     <= s_br[k];
        ex_u_imm     <= s_ui[k];
        ex_store_v   <= s_st[k];
        drv_line     <= k;
        // rs1 hits the entry now in writeback, rs2 the one before it
        rs1_s        <= (k > 0) ? s_rd[k-1] : 5'd0;
        rs2_s        <= (k > 1) ? s_rd[k-2] : 5'd0;
    endtask

    task automatic drive_bubble();
        ex_valid     <= 1'b0;
        ex_mem_read  <= 1'b0;
        ex_mem_write <= 1'b0;
        ex_regf_we   <= 1'b1;                          // Only valid may block the write
        drv_line     <= -1;
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        ex_valid     = 1'b1;                           // Entry held in reset must not retire
        ex_pc        = '0;
        ex_funct3    = '0;
        ex_mem_read  = 1'b0;
        ex_mem_write = 1'b0;
        ex_regf_we   = 1'b1;
        ex_wb_sel    = alu_out_wb;
        ex_rd_s      = 5'd1;
        ex_alu_out   = '1;
        ex_br_en     = '0;
        ex_u_imm     = '0;
        ex_store_v   = '0;
        rs1_s        = '0;
        rs2_s        = '0;
        sweep        = 1'b0;
        drv_line     = -1;
        reg_line     = -1;
        loaded       = 1'b0;
        read_stimulus();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        rst      <= 1'b0;
        ex_valid <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            sweep <= 1'b1;
            rs1_s <= reg_idx_t'(2 * i);
            rs2_s <= reg_idx_t'(2 * i + 1);
        end
        for (int k = 0; k < n_i; k++) begin
            @(posedge clk);
            sweep <= 1'b0;
            drive_entry(k);
        end
        for (int j = 0; j < n_r; j++) begin
            @(posedge clk);
            sweep <= 1'b0;
            drive_bubble();
            reg_line <= j;
            rs1_s    <= r_idx[j];
            rs2_s    <= r_idx[n_r-1-j];
        end
        @(posedge clk);
        sweep <= 1'b0;
        drive_bubble();
        reg_line <= -1;
        @(posedge clk);
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && load_ok && n_i > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // ------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------
    initial begin
        int limit;
        wait (loaded === 1'b1);
        limit = (3 + 16 + n_i + n_r + 2 + 20) * clk_period;
        #(limit);
        $display("Timeout: the run did not finish within %0d ns", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
